// ==== all.f ====
+incdir+design
+incdir+verification
design/pipeline_types_pkg.sv
design/data_ram.sv
design/dcache_port.sv
design/mem_stage.sv
design/mem_subsys_top.sv
verification/tb_mem_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_mem_subsys \
    -o tb_mem_subsys > build.log 2>&1 \
    && ./obj_dir/tb_mem_subsys > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Some tests failed" sim.log \
    && { echo "simulation FAILED, see sim.log"; exit 1; } \
    || { echo "simulation PASSED"; exit 0; }

// ==== verification/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// counts a mismatch for the run and for the current test
task automatic count_error();
    errors++;
    row_errors++;
endtask

task automatic check_wb(input string name, input mem_wb_t exp, input mem_wb_t act);
    if (act !== exp) begin
        $display("[FAIL] %s writeback: expected %h actual %h", name, exp, act);
        count_error();
    end
endtask

task automatic check_pf(input string name, input push_forward_t exp,
                        input push_forward_t act);
    if (act !== exp) begin
        $display("[FAIL] %s reg forward: expected %h actual %h", name, exp, act);
        count_error();
    end
endtask

task automatic check_csr_pf(input string name, input csr_push_forward_t exp,
                            input csr_push_forward_t act);
    if (act !== exp) begin
        $display("[FAIL] %s csr forward: expected %h actual %h", name, exp, act);
        count_error();
    end
endtask

task automatic check_commit(input string name, input commit_ctrl_t exp,
                            input commit_ctrl_t act);
    if (act !== exp) begin
        $display("[FAIL] %s commit: expected %h actual %h", name, exp, act);
        count_error();
    end
endtask

task automatic check_pause(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("[FAIL] %s pause seen: expected %0b actual %0b", name, exp, act);
        count_error();
    end
endtask

`endif

// ==== verification/tb_mem_subsys.sv ====
`timescale 1ns/100ps
`include "core_defines.svh"

module tb_mem_subsys;
    import pipeline_types_pkg::*;

    typedef struct packed {
        ex_mem_t      slot1;
        ex_mem_t      slot0;
        mem_wb_t      exp_wb;
        commit_ctrl_t exp_cc;
        logic         exp_pause;
    } test_row_t;

    logic                             clk;
    logic                             arst_n;
    ex_mem_t [`ISSUE_WIDTH-1:0]       ex_mem;
    mem_wb_t [`ISSUE_WIDTH-1:0]       wb;
    push_forward_t [`ISSUE_WIDTH-1:0] reg_pf;
    csr_push_forward_t                csr_pf;
    commit_ctrl_t [`ISSUE_WIDTH-1:0]  commit_ctrl;
    logic                             pause_mem;

    test_row_t rows[$];
    string     names[$];
    bus32_t    ref_mem [`RAM_WORDS];
    bus32_t    pc_next;
    int        seed;
    int        errors;
    int        row_errors;
    int        n_fail;
    logic      table_ready;

    `include "tb_checks.svh"

    mem_subsys_top dut (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .ex_mem_i      (ex_mem),
        .wb_o          (wb),
        .reg_pf_o      (reg_pf),
        .csr_pf_o      (csr_pf),
        .commit_ctrl_o (commit_ctrl),
        .pause_mem_o   (pause_mem)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // slot that bypasses memory
    function automatic mem_wb_t pass_wb(input ex_mem_t s);
        mem_wb_t w;
        w.reg_write_en   = s.reg_write_en;
        w.reg_write_addr = s.reg_write_addr;
        w.reg_write_data = s.reg_write_data;
        w.csr_write_en   = s.csr_write_en;
        w.csr_write_addr = s.csr_addr;
        w.csr_write_data = s.csr_write_data;
        w.is_llw_scw     = s.is_llw_scw;
        return w;
    endfunction

    // commit record carries the slot fields unchanged
    function automatic commit_ctrl_t commit_of(input ex_mem_t s);
        commit_ctrl_t c;
        c.is_exception    = s.is_exception;
        c.exception_cause = s.exception_cause;
        c.pc              = s.pc;
        c.mem_addr        = s.mem_addr;
        c.aluop           = s.aluop;
        return c;
    endfunction

    function automatic bus32_t extract_load(input logic [7:0] op, input logic [1:0] off,
                                            input bus32_t word);
        bus32_t sh;
        sh = word >> (8 * off);
        case (op)
            `ALU_LDB:  return {{24{sh[7]}}, sh[7:0]};
            `ALU_LDBU: return sh & 32'h0000_00ff;
            `ALU_LDH:  return off[0] ? 32'b0 : {{16{sh[15]}}, sh[15:0]};
            `ALU_LDHU: return off[0] ? 32'b0 : sh & 32'h0000_ffff;
            default:   return word;
        endcase
    endfunction

    // expected results come from the reference memory before a store updates it
    task automatic add_row(input string name, input ex_mem_t s0, input ex_mem_t s1);
        test_row_t  row;
        logic       is_ld;
        logic       is_st;
        logic       live;
        bus32_t     shift;
        bus32_t     mask;
        logic [7:0] idx;
        is_ld = s0.aluop inside {`ALU_LDB, `ALU_LDBU, `ALU_LDH, `ALU_LDHU, `ALU_LDW, `ALU_LLW};
        is_st = s0.aluop inside {`ALU_STB, `ALU_STH, `ALU_STW, `ALU_SCW};
        live = (is_ld || is_st) && !s0.is_exception[1];
        idx = s0.mem_addr[9:2];
        row.slot0 = s0;
        row.slot1 = s1;
        row.exp_wb = pass_wb(s0);
        if (is_ld) begin
            row.exp_wb.reg_write_data = live ?
                extract_load(s0.aluop, s0.mem_addr[1:0], ref_mem[idx]) : 32'b0;
        end
        if (is_st && live) begin
            shift = 8 * s0.mem_addr[1:0];
            mask  = 32'hffff_ffff;
            if (s0.aluop == `ALU_STB) begin
                mask = 32'h0000_00ff << shift;
            end else if (s0.aluop == `ALU_STH) begin
                shift = 16 * s0.mem_addr[1];
                mask  = 32'h0000_ffff << shift;
            end else begin
                shift = 0;
            end
            ref_mem[idx] = (ref_mem[idx] & ~mask) | ((s0.mem_data << shift) & mask);
        end
        row.exp_cc = commit_of(s0);
        row.exp_pause = live;
        rows.push_back(row);
        names.push_back(name);
    endtask

    task automatic mem_row(input string name, input logic [7:0] op, input bus32_t addr,
                           input bus32_t data, input logic [4:0] rd, input logic excp);
        ex_mem_t s0;
        ex_mem_t s1;
        s0 = '0;
        s1 = '0;
        s0.pc              = pc_next;
        s0.aluop           = op;
        s0.mem_addr        = addr;
        s0.mem_data        = data;
        s0.reg_write_en    = (rd != 5'd0);
        s0.reg_write_addr  = rd;
        s0.is_llw_scw      = (op == `ALU_LLW) || (op == `ALU_SCW);
        s0.is_exception    = excp ? 2'b10 : 2'b00;
        s0.exception_cause = excp ? 7'h05 : 7'h00;
        s1.pc    = pc_next + 4;
        s1.aluop = `ALU_ADD;
        pc_next  = pc_next + 8;
        add_row(name, s0, s1);
    endtask

    task automatic build_table();
        ex_mem_t s0;
        ex_mem_t s1;
        mem_row("stw_a", `ALU_STW, 32'h40, $random(seed), 5'd0, 1'b0);
        mem_row("ldw_a", `ALU_LDW, 32'h40, 32'b0, 5'd2, 1'b0);
        // bytes of mixed sign in both halves
        mem_row("stw_b", `ALU_STW, 32'h104, 32'h8c7f_01f3, 5'd0, 1'b0);
        for (int k = 0; k < 4; k++) begin
            mem_row($sformatf("ldb_b+%0d", k), `ALU_LDB, 32'h104 + k, 32'b0, 5'd3, 1'b0);
            mem_row($sformatf("ldbu_b+%0d", k), `ALU_LDBU, 32'h104 + k, 32'b0, 5'd3, 1'b0);
        end
        for (int k = 0; k < 4; k += 2) begin
            mem_row($sformatf("ldh_b+%0d", k), `ALU_LDH, 32'h104 + k, 32'b0, 5'd4, 1'b0);
            mem_row($sformatf("ldhu_b+%0d", k), `ALU_LDHU, 32'h104 + k, 32'b0, 5'd4, 1'b0);
        end
        mem_row("ldh_b+1", `ALU_LDH, 32'h105, 32'b0, 5'd4, 1'b0);
        mem_row("ldhu_b+3", `ALU_LDHU, 32'h107, 32'b0, 5'd4, 1'b0);
        mem_row("stw_c", `ALU_STW, 32'h208, $random(seed), 5'd0, 1'b0);
        mem_row("stb_c+2", `ALU_STB, 32'h20a, $random(seed), 5'd0, 1'b0);
        mem_row("ldw_c_byte", `ALU_LDW, 32'h208, 32'b0, 5'd5, 1'b0);
        mem_row("sth_c+2", `ALU_STH, 32'h20a, $random(seed), 5'd0, 1'b0);
        mem_row("ldw_c_half", `ALU_LDW, 32'h208, 32'b0, 5'd5, 1'b0);
        mem_row("scw_d", `ALU_SCW, 32'h10, $random(seed), 5'd0, 1'b0);
        mem_row("llw_d", `ALU_LLW, 32'h10, 32'b0, 5'd6, 1'b0);
        // register and csr results only
        s0 = '0;
        s1 = '0;
        s0.pc             = pc_next;
        s0.aluop          = `ALU_ADD;
        s0.reg_write_en   = 1'b1;
        s0.reg_write_addr = 5'd7;
        s0.reg_write_data = $random(seed);
        s0.csr_write_en   = 1'b1;
        s0.csr_addr       = 14'h0300;
        s0.csr_write_data = $random(seed);
        s1.pc             = pc_next + 4;
        s1.aluop          = `ALU_ADD;
        s1.reg_write_en   = 1'b1;
        s1.reg_write_addr = 5'd9;
        s1.reg_write_data = $random(seed);
        pc_next = pc_next + 8;
        add_row("add_csr", s0, s1);
        mem_row("stw_e", `ALU_STW, 32'h3fc, $random(seed), 5'd0, 1'b0);
        mem_row("ldw_e_excp", `ALU_LDW, 32'h3fc, 32'b0, 5'd8, 1'b1);
        mem_row("stw_e_excp", `ALU_STW, 32'h3fc, $random(seed), 5'd0, 1'b1);
        mem_row("ldw_e", `ALU_LDW, 32'h3fc, 32'b0, 5'd8, 1'b0);
        mem_row("b2b_ldw_a", `ALU_LDW, 32'h40, 32'b0, 5'd10, 1'b0);
        mem_row("b2b_ldw_c", `ALU_LDW, 32'h208, 32'b0, 5'd11, 1'b0);
        mem_row("b2b_ldb_b+3", `ALU_LDB, 32'h107, 32'b0, 5'd12, 1'b0);
        mem_row("b2b_llw_e", `ALU_LLW, 32'h3fc, 32'b0, 5'd13, 1'b0);
    endtask

    task automatic run_row(input int i);
        test_row_t         row;
        mem_wb_t           wb1_exp;
        push_forward_t     pf_exp;
        csr_push_forward_t csr_exp;
        logic              paused;
        row = rows[i];
        wb1_exp = pass_wb(row.slot1);
        row_errors = 0;
        paused = 1'b0;
        @(posedge clk);
        #1;
        ex_mem[0] = row.slot0;
        ex_mem[1] = row.slot1;
        // outputs are read mid-cycle once the stage lets go
        @(negedge clk);
        while (pause_mem) begin
            paused = 1'b1;
            @(negedge clk);
        end
        check_pause(names[i], row.exp_pause, paused);
        check_wb(names[i], row.exp_wb, wb[0]);
        check_wb(names[i], wb1_exp, wb[1]);
        pf_exp = {row.exp_wb.reg_write_en, row.exp_wb.reg_write_addr, row.exp_wb.reg_write_data};
        check_pf(names[i], pf_exp, reg_pf[0]);
        pf_exp = {wb1_exp.reg_write_en, wb1_exp.reg_write_addr, wb1_exp.reg_write_data};
        check_pf(names[i], pf_exp, reg_pf[1]);
        csr_exp = {row.exp_wb.csr_write_en, row.exp_wb.csr_write_addr,
                   row.exp_wb.csr_write_data};
        check_csr_pf(names[i], csr_exp, csr_pf);
        check_commit(names[i], row.exp_cc, commit_ctrl[0]);
        check_commit(names[i], commit_of(row.slot1), commit_ctrl[1]);
        if (row_errors != 0) begin
            n_fail++;
        end
        $display("test %-14s %s", names[i], (row_errors == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        seed        = 32'h3764;
        errors      = 0;
        n_fail      = 0;
        pc_next     = 32'h0000_1000;
        table_ready = 1'b0;
        arst_n      = 1'b0;
        ex_mem      = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("tests run %0d, ok %0d, with mismatches %0d, total mismatches %0d",
                 rows.size(), rows.size() - n_fail, n_fail, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // generous bound per row plus reset
    initial begin
        wait (table_ready === 1'b1);
        repeat (rows.size() * 20 + 10) @(posedge clk);
        $display("watchdog expired before the last test finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== design/mem_subsys_top.sv ====
`timescale 1ns/100ps
`include "core_defines.svh"

module mem_subsys_top (
    input  logic                                                clk,
    input  logic                                                arst_n_i,
    input  pipeline_types_pkg::ex_mem_t [`ISSUE_WIDTH-1:0]      ex_mem_i,
    output pipeline_types_pkg::mem_wb_t [`ISSUE_WIDTH-1:0]      wb_o,
    output pipeline_types_pkg::push_forward_t [`ISSUE_WIDTH-1:0] reg_pf_o,
    output pipeline_types_pkg::csr_push_forward_t               csr_pf_o,
    output pipeline_types_pkg::commit_ctrl_t [`ISSUE_WIDTH-1:0] commit_ctrl_o,
    output logic                                                pause_mem_o
);
    import pipeline_types_pkg::*;

    dcache_req_t  dc_req;
    dcache_rsp_t  dc_rsp;
    mem_bus_req_t bus_req;
    mem_bus_rsp_t bus_rsp;

    mem_stage u_mem_stage (
        .arst_n_i      (arst_n_i),
        .clk           (clk),
        .ex_mem_i      (ex_mem_i),
        .dc_req_o      (dc_req),
        .dc_rsp_i      (dc_rsp),
        .wb_o          (wb_o),
        .reg_pf_o      (reg_pf_o),
        .csr_pf_o      (csr_pf_o),
        .commit_ctrl_o (commit_ctrl_o),
        .pause_mem_o   (pause_mem_o)
    );

    dcache_port u_dcache_port (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .dc_req_i  (dc_req),
        .dc_rsp_o  (dc_rsp),
        .bus_req_o (bus_req),
        .bus_rsp_i (bus_rsp)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp)
    );

endmodule

// ==== design/mem_stage.sv ====
`timescale 1ns/100ps
`include "core_defines.svh"

module mem_stage (
    input  logic                                                arst_n_i,
    input  logic                                                clk,
    input  pipeline_types_pkg::ex_mem_t [`ISSUE_WIDTH-1:0]      ex_mem_i,
    output pipeline_types_pkg::dcache_req_t                     dc_req_o,
    input  pipeline_types_pkg::dcache_rsp_t                     dc_rsp_i,
    output pipeline_types_pkg::mem_wb_t [`ISSUE_WIDTH-1:0]      wb_o,
    output pipeline_types_pkg::push_forward_t [`ISSUE_WIDTH-1:0] reg_pf_o,
    output pipeline_types_pkg::csr_push_forward_t               csr_pf_o,
    output pipeline_types_pkg::commit_ctrl_t [`ISSUE_WIDTH-1:0] commit_ctrl_o,
    output logic                                                pause_mem_o
);
    import pipeline_types_pkg::*;

    ex_mem_t    slot0;
    logic       is_load;
    logic       is_store;
    logic       excp_before;
    logic       served_q;
    bus32_t     rd_word;
    logic [7:0] rd_byte;
    logic [15:0] rd_half;
    bus32_t     load_data;
    logic [3:0] st_be;
    bus32_t     st_wdata;

    assign slot0       = ex_mem_i[0];
    assign excp_before = slot0.is_exception[1];

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (slot0.aluop)
            `ALU_LDB, `ALU_LDBU, `ALU_LDH, `ALU_LDHU, `ALU_LDW, `ALU_LLW: begin
                is_load = 1'b1;
            end
            `ALU_STB, `ALU_STH, `ALU_STW, `ALU_SCW: begin
                is_store = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // load data stays zero until the port answers
    assign rd_word = dc_rsp_i.data_ok ? dc_rsp_i.rdata : 32'b0;
    assign rd_byte = rd_word[{slot0.mem_addr[1:0], 3'b000} +: 8];
    assign rd_half = slot0.mem_addr[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        load_data = 32'b0;
        case (slot0.aluop)
            `ALU_LDB:  load_data = {{24{rd_byte[7]}}, rd_byte};
            `ALU_LDBU: load_data = {24'b0, rd_byte};
            // odd halfword address reads as zero
            `ALU_LDH:  load_data = slot0.mem_addr[0] ? 32'b0 : {{16{rd_half[15]}}, rd_half};
            `ALU_LDHU: load_data = slot0.mem_addr[0] ? 32'b0 : {16'b0, rd_half};
            `ALU_LDW, `ALU_LLW: begin
                load_data = rd_word;
            end
            default: begin
                load_data = 32'b0;
            end
        endcase
    end

    // store lanes, data replicated so the enables pick the lane
    always_comb begin
        st_be    = 4'b1111;
        st_wdata = slot0.mem_data;
        case (slot0.aluop)
            `ALU_STB: begin
                st_be    = 4'b0001 << slot0.mem_addr[1:0];
                st_wdata = {4{slot0.mem_data[7:0]}};
            end
            `ALU_STH: begin
                st_be    = slot0.mem_addr[1] ? 4'b1100 : 4'b0011;
                st_wdata = {2{slot0.mem_data[15:0]}};
            end
            default: begin
            end
        endcase
    end

    // blocks a repeat request in the cycle after completion
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            served_q <= 1'b0;
        end else begin
            served_q <= dc_rsp_i.data_ok;
        end
    end

    assign dc_req_o.valid = (is_load || is_store) && !excp_before && !served_q;
    assign dc_req_o.we    = is_store;
    assign dc_req_o.addr  = slot0.mem_addr[31:2];
    assign dc_req_o.be    = st_be;
    assign dc_req_o.wdata = st_wdata;

    assign pause_mem_o = (is_load || is_store) && !excp_before && !dc_rsp_i.data_ok;

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_slot
        assign wb_o[i].reg_write_en   = ex_mem_i[i].reg_write_en;
        assign wb_o[i].reg_write_addr = ex_mem_i[i].reg_write_addr;
        assign wb_o[i].csr_write_en   = ex_mem_i[i].csr_write_en;
        assign wb_o[i].csr_write_addr = ex_mem_i[i].csr_addr;
        assign wb_o[i].csr_write_data = ex_mem_i[i].csr_write_data;
        assign wb_o[i].is_llw_scw     = ex_mem_i[i].is_llw_scw;

        if (i == 0) begin : g_mem_slot
            assign wb_o[i].reg_write_data = is_load ? load_data : ex_mem_i[i].reg_write_data;
        end else begin : g_pass_slot
            assign wb_o[i].reg_write_data = ex_mem_i[i].reg_write_data;
        end

        assign reg_pf_o[i].reg_write_en   = wb_o[i].reg_write_en;
        assign reg_pf_o[i].reg_write_addr = wb_o[i].reg_write_addr;
        assign reg_pf_o[i].reg_write_data = wb_o[i].reg_write_data;

        assign commit_ctrl_o[i].is_exception    = ex_mem_i[i].is_exception;
        assign commit_ctrl_o[i].exception_cause = ex_mem_i[i].exception_cause;
        assign commit_ctrl_o[i].pc              = ex_mem_i[i].pc;
        assign commit_ctrl_o[i].mem_addr        = ex_mem_i[i].mem_addr;
        assign commit_ctrl_o[i].aluop           = ex_mem_i[i].aluop;
    end

    // only slot 0 carries csr writes
    assign csr_pf_o.csr_write_en   = wb_o[0].csr_write_en;
    assign csr_pf_o.csr_write_addr = wb_o[0].csr_write_addr;
    assign csr_pf_o.csr_write_data = wb_o[0].csr_write_data;

    // an excepted slot never sees an access complete
    a_no_access_on_excp: assert property (@(posedge clk) disable iff (!arst_n_i)
        excp_before |-> !dc_rsp_i.data_ok);

    // upstream keeps the slot while the stage holds it
    a_slot_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        pause_mem_o |=> $stable(ex_mem_i[0]));

endmodule

// ==== design/dcache_port.sv ====
`timescale 1ns/100ps

module dcache_port (
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  pipeline_types_pkg::dcache_req_t   dc_req_i,
    output pipeline_types_pkg::dcache_rsp_t   dc_rsp_o,
    output pipeline_types_pkg::mem_bus_req_t  bus_req_o,
    input  pipeline_types_pkg::mem_bus_rsp_t  bus_rsp_i
);
    import pipeline_types_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ACK,
        ST_RELEASE,
        ST_ACK_LOW
    } port_state_e;

    port_state_e state_q;
    logic        req_q;
    logic        launch;
    logic        we_q;
    word_addr_t  addr_q;
    logic [3:0]  be_q;
    bus32_t      wdata_q;

    // a new handshake only starts once the old ack is gone
    assign launch = (state_q == ST_IDLE) && dc_req_i.valid && !bus_rsp_i.ack;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            req_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (launch) begin
                        req_q   <= 1'b1;
                        state_q <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    if (bus_rsp_i.ack) begin
                        req_q   <= 1'b0;
                        state_q <= ST_RELEASE;
                    end
                end
                // memory sees req low one cycle later
                ST_RELEASE: begin
                    state_q <= ST_ACK_LOW;
                end
                ST_ACK_LOW: begin
                    if (!bus_rsp_i.ack) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                    req_q   <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            we_q    <= dc_req_i.we;
            addr_q  <= dc_req_i.addr;
            be_q    <= dc_req_i.be;
            wdata_q <= dc_req_i.wdata;
        end
    end

    assign bus_req_o.req   = req_q;
    assign bus_req_o.we    = we_q;
    assign bus_req_o.addr  = addr_q;
    assign bus_req_o.be    = be_q;
    assign bus_req_o.wdata = wdata_q;

    // rdata is taken in the ack cycle itself
    assign dc_rsp_o.data_ok = (state_q == ST_WAIT_ACK) && bus_rsp_i.ack;
    assign dc_rsp_o.rdata   = bus_rsp_i.rdata;

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        bus_req_o.req && !bus_rsp_i.ack |=> bus_req_o.req && $stable(bus_req_o));

    a_data_ok_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        dc_rsp_o.data_ok |=> !dc_rsp_o.data_ok);

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/100ps
`include "core_defines.svh"

module data_ram (
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  pipeline_types_pkg::mem_bus_req_t  bus_req_i,
    output pipeline_types_pkg::mem_bus_rsp_t  bus_rsp_o
);
    import pipeline_types_pkg::*;

    localparam int ADDR_W = $clog2(`RAM_WORDS);
    localparam int CNT_W  = $clog2(`RAM_LATENCY + 1);

    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_COUNT,
        RAM_ACK
    } ram_state_e;

    ram_state_e        state_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              ack_q;
    logic              fire;
    logic [ADDR_W-1:0] idx;
    bus32_t            rdata_q;
    bus32_t            mem [`RAM_WORDS];

    assign idx  = bus_req_i.addr[ADDR_W-1:0];
    assign fire = (state_q == RAM_COUNT) && (cnt_q < CNT_W'(2));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RAM_IDLE;
            cnt_q   <= '0;
            ack_q   <= 1'b0;
        end else begin
            case (state_q)
                RAM_IDLE: begin
                    if (bus_req_i.req) begin
                        cnt_q   <= CNT_W'(`RAM_LATENCY - 1);
                        state_q <= RAM_COUNT;
                    end
                end
                RAM_COUNT: begin
                    if (fire) begin
                        ack_q   <= 1'b1;
                        state_q <= RAM_ACK;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                // hold ack until the requester lets go
                RAM_ACK: begin
                    if (!bus_req_i.req) begin
                        ack_q   <= 1'b0;
                        state_q <= RAM_IDLE;
                    end
                end
                default: begin
                    state_q <= RAM_IDLE;
                    ack_q   <= 1'b0;
                end
            endcase
        end
    end

    // old word is returned on a write
    always_ff @(posedge clk) begin
        if (fire) begin
            rdata_q <= mem[idx];
            if (bus_req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_req_i.be[b]) begin
                        mem[idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    assign bus_rsp_o.ack   = ack_q;
    assign bus_rsp_o.rdata = rdata_q;

endmodule

// ==== design/pipeline_types_pkg.sv ====
package pipeline_types_pkg;

    typedef logic [31:0] bus32_t;

    // word address, byte address bits 31:2
    typedef logic [29:0] word_addr_t;

    // one slot from execute
    typedef struct packed {
        bus32_t      pc;
        logic [7:0]  aluop;
        bus32_t      mem_addr;
        // store source
        bus32_t      mem_data;
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        bus32_t      reg_write_data;
        logic        csr_write_en;
        logic [13:0] csr_addr;
        bus32_t      csr_write_data;
        // bit 1 set by an earlier stage
        logic [1:0]  is_exception;
        logic [6:0]  exception_cause;
        logic        is_llw_scw;
    } ex_mem_t;

    // one slot to writeback
    typedef struct packed {
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        bus32_t      reg_write_data;
        logic        csr_write_en;
        logic [13:0] csr_write_addr;
        bus32_t      csr_write_data;
        logic        is_llw_scw;
    } mem_wb_t;

    typedef struct packed {
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        bus32_t      reg_write_data;
    } push_forward_t;

    typedef struct packed {
        logic        csr_write_en;
        logic [13:0] csr_write_addr;
        bus32_t      csr_write_data;
    } csr_push_forward_t;

    typedef struct packed {
        logic [1:0]  is_exception;
        logic [6:0]  exception_cause;
        bus32_t      pc;
        bus32_t      mem_addr;
        logic [7:0]  aluop;
    } commit_ctrl_t;

    // stage to cache port
    typedef struct packed {
        logic        valid;
        logic        we;
        word_addr_t  addr;
        logic [3:0]  be;
        bus32_t      wdata;
    } dcache_req_t;

    typedef struct packed {
        // high for one cycle
        logic        data_ok;
        bus32_t      rdata;
    } dcache_rsp_t;

    // four-phase bus to the data memory
    typedef struct packed {
        logic        req;
        logic        we;
        word_addr_t  addr;
        logic [3:0]  be;
        bus32_t      wdata;
    } mem_bus_req_t;

    typedef struct packed {
        logic        ack;
        bus32_t      rdata;
    } mem_bus_rsp_t;

endpackage

// ==== design/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// slots per cycle
`define ISSUE_WIDTH 2

// loads
`define ALU_LDB   8'h21
`define ALU_LDBU  8'h22
`define ALU_LDH   8'h23
`define ALU_LDHU  8'h24
`define ALU_LDW   8'h25
`define ALU_LLW   8'h26

// stores, sc is written like a word store
`define ALU_STB   8'h31
`define ALU_STH   8'h32
`define ALU_STW   8'h33
`define ALU_SCW   8'h34

// plain register result, no memory access
`define ALU_ADD   8'h01

// data memory depth in words
`define RAM_WORDS 256

// cycles from req to ack, two at least
`define RAM_LATENCY 2

`endif
